// ==== hdl/yolo_write_bus_pkg.sv ====
package yolo_write_bus_pkg;

   // external byte address and databus word
   localparam int IO_ADDR_W = 32;
   localparam int DATABUS_W = 64;

   // log2 of bytes per databus word
   localparam int WORD_SHIFT = 3;

   localparam int STRB_W = DATABUS_W / 8;

   typedef logic [DATABUS_W-1:0] bus_word_t;

   // one write request as it travels to the databus
   typedef struct packed {
      logic [IO_ADDR_W-1:0] addr;
      bus_word_t            wdata;
      logic [STRB_W-1:0]    wstrb;
   } wr_req_t;

endpackage

// ==== hdl/yolo_write_cfg_pkg.sv ====
package yolo_write_cfg_pkg;

   // internal address, iterations, shift and increment
   localparam int MEM_ADDR_W = 10;
   localparam int PERIOD_W = 10;
   localparam int CPU_ADDR_W = 4;

   // stage offset is half an external address
   localparam int OFFSET_W = yolo_write_bus_pkg::IO_ADDR_W / 2;

   // cpu register map
   localparam logic [CPU_ADDR_W-1:0] REG_EXT_ADDR = 0;
   localparam logic [CPU_ADDR_W-1:0] REG_OFFSET = 1;
   localparam logic [CPU_ADDR_W-1:0] REG_START = 2;
   localparam logic [CPU_ADDR_W-1:0] REG_ITER = 3;
   localparam logic [CPU_ADDR_W-1:0] REG_PER = 4;
   localparam logic [CPU_ADDR_W-1:0] REG_SHIFT = 5;
   localparam logic [CPU_ADDR_W-1:0] REG_INCR = 6;

   // configuration of one layer
   typedef struct packed {
      logic [yolo_write_bus_pkg::IO_ADDR_W-1:0] ext_addr;
      logic [OFFSET_W-1:0]                      offset;
      logic [MEM_ADDR_W-1:0]                    start;
      logic [MEM_ADDR_W-1:0]                    iter;
      logic [PERIOD_W-1:0]                      per;
      logic [MEM_ADDR_W-1:0]                    shift;
      logic [MEM_ADDR_W-1:0]                    incr;
   } layer_conf_t;

endpackage

// ==== hdl/conf_regs.sv ====
`timescale 1ns/10ps

module conf_regs (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          clear,
   input  logic                                          valid,
   input  logic [yolo_write_cfg_pkg::CPU_ADDR_W-1:0]     addr,
   input  logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]      wdata,
   input  logic                                          run,
   output yolo_write_cfg_pkg::layer_conf_t               conf,
   output logic                                          start
);

   localparam int MEM_ADDR_W = yolo_write_cfg_pkg::MEM_ADDR_W;
   localparam int PERIOD_W = yolo_write_cfg_pkg::PERIOD_W;
   localparam int OFFSET_W = yolo_write_cfg_pkg::OFFSET_W;

   yolo_write_cfg_pkg::layer_conf_t work;
   logic [2:0]                      run_d;

   // cpu side working registers
   always_ff @(posedge clk, posedge rst, posedge clear) begin
      if (rst || clear) begin
         work <= '0;
      end else if (valid) begin
         case (addr)
            yolo_write_cfg_pkg::REG_EXT_ADDR: begin
               work.ext_addr <= wdata;
            end
            yolo_write_cfg_pkg::REG_OFFSET: begin
               work.offset <= wdata[OFFSET_W-1:0];
            end
            yolo_write_cfg_pkg::REG_START: begin
               work.start <= wdata[MEM_ADDR_W-1:0];
            end
            yolo_write_cfg_pkg::REG_ITER: begin
               work.iter <= wdata[MEM_ADDR_W-1:0];
            end
            yolo_write_cfg_pkg::REG_PER: begin
               work.per <= wdata[PERIOD_W-1:0];
            end
            yolo_write_cfg_pkg::REG_SHIFT: begin
               work.shift <= wdata[MEM_ADDR_W-1:0];
            end
            yolo_write_cfg_pkg::REG_INCR: begin
               work.incr <= wdata[MEM_ADDR_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // shadow copy lets the cpu set up the next layer
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         conf <= '0;
      end else if (run) begin
         conf <= work;
      end
   end

   // start waits for the base pipeline to settle
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         run_d <= '0;
      end else begin
         run_d <= {run_d[1:0], run};
      end
   end

   assign start = run_d[2];

endmodule

// ==== hdl/stage_base_calc.sv ====
`timescale 1ns/10ps

module stage_base_calc #(
   parameter int N_STAGES = 4
) (
   input  logic                                                  clk,
   input  logic                                                  rst,
   input  logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]              ext_addr,
   input  logic [yolo_write_cfg_pkg::OFFSET_W-1:0]               offset,
   output logic [N_STAGES-1:0][yolo_write_bus_pkg::IO_ADDR_W-1:0] base
);

   localparam int AW = yolo_write_bus_pkg::IO_ADDR_W;

   logic [AW-1:0] ext_q;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         ext_q <= '0;
      end else begin
         ext_q <= ext_addr;
      end
   end

   for (genvar i = 0; i < N_STAGES; i++) begin : g_base
      logic [AW-1:0] base_q;

      if (i == 0) begin : g_first
         // stage 0 has no product and only matches the latency
         always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
               base_q <= '0;
            end else begin
               base_q <= ext_q;
            end
         end
      end else begin : g_mul
         localparam logic [AW-1:0] IDX = AW'(i);

         logic [AW-1:0] prod_q;

         always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
               prod_q <= '0;
               base_q <= '0;
            end else begin
               prod_q <= IDX * AW'(offset);
               base_q <= ext_q + prod_q;
            end
         end
      end

      assign base[i] = base_q;
   end

endmodule

// ==== hdl/write_addr_gen.sv ====
`timescale 1ns/10ps

module write_addr_gen (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      start,
   input  logic                                      pause,
   input  yolo_write_cfg_pkg::layer_conf_t           conf,
   output logic [yolo_write_cfg_pkg::MEM_ADDR_W-1:0] addr,
   output logic                                      en,
   output logic                                      busy
);

   localparam int MEM_ADDR_W = yolo_write_cfg_pkg::MEM_ADDR_W;
   localparam int PERIOD_W = yolo_write_cfg_pkg::PERIOD_W;

   logic [MEM_ADDR_W-1:0] iter_cnt;
   logic [PERIOD_W-1:0]   per_cnt;
   // start plus j times shift
   logic [MEM_ADDR_W-1:0] iter_base;
   logic                  last_per;
   logic                  last_iter;

   assign en = busy & ~pause;
   assign last_per = (per_cnt == conf.per - 1'b1);
   assign last_iter = (iter_cnt == conf.iter - 1'b1);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         iter_cnt <= '0;
         per_cnt <= '0;
         iter_base <= '0;
         addr <= '0;
      end else if (start) begin
         // empty loop never goes busy
         busy <= (conf.iter != '0) && (conf.per != '0);
         iter_cnt <= '0;
         per_cnt <= '0;
         iter_base <= conf.start;
         addr <= conf.start;
      end else if (en) begin
         if (last_per) begin
            per_cnt <= '0;
            if (last_iter) begin
               busy <= 1'b0;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
               iter_base <= iter_base + conf.shift;
               addr <= iter_base + conf.shift;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr <= addr + conf.incr;
         end
      end
   end

endmodule

// ==== hdl/write_stage.sv ====
`timescale 1ns/10ps

module write_stage (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      capture,
   input  logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]  stage_base,
   input  logic [yolo_write_cfg_pkg::MEM_ADDR_W-1:0] int_addr,
   input  yolo_write_bus_pkg::bus_word_t             lane,
   input  logic                                      grant,
   output logic                                      req,
   output yolo_write_bus_pkg::wr_req_t               req_data
);

   localparam int AW = yolo_write_bus_pkg::IO_ADDR_W;

   logic [AW-1:0] word_offset;

   // internal word index to byte offset
   assign word_offset = AW'(int_addr) << yolo_write_bus_pkg::WORD_SHIFT;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         req <= 1'b0;
      end else if (capture) begin
         req <= 1'b1;
      end else if (grant) begin
         req <= 1'b0;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         req_data <= '0;
      end else if (capture) begin
         req_data.addr <= stage_base + word_offset;
         req_data.wdata <= lane;
         req_data.wstrb <= '1;
      end
   end

endmodule

// ==== hdl/req_merge.sv ====
`timescale 1ns/10ps

module req_merge #(
   parameter int N_STAGES = 4
) (
   input  logic [N_STAGES-1:0]                        reqs,
   input  yolo_write_bus_pkg::wr_req_t [N_STAGES-1:0] req_data,
   input  logic                                       databus_ready,
   output logic [N_STAGES-1:0]                        grants,
   output logic                                       databus_valid,
   output yolo_write_bus_pkg::wr_req_t                databus_req
);

   localparam int SEL_W = (N_STAGES > 1) ? $clog2(N_STAGES) : 1;

   logic [SEL_W-1:0] sel;

   // scan from the top down so the lowest index wins
   always_comb begin
      sel = '0;
      for (int i = N_STAGES - 1; i >= 0; i--) begin
         if (reqs[i]) begin
            sel = SEL_W'(i);
         end
      end
   end

   assign databus_valid = |reqs;
   assign databus_req = req_data[sel];

   always_comb begin
      grants = '0;
      if (databus_valid && databus_ready) begin
         grants[sel] = 1'b1;
      end
   end

endmodule

// ==== hdl/yolo_write_top.sv ====
`timescale 1ns/10ps

module yolo_write_top #(
   parameter int N_STAGES = 4
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          clear,
   input  logic                                          valid,
   input  logic [yolo_write_cfg_pkg::CPU_ADDR_W-1:0]     addr,
   input  logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]      wdata,
   input  logic                                          run,
   input  yolo_write_bus_pkg::bus_word_t [N_STAGES-1:0]  flow_in,
   input  logic                                          databus_ready,
   output logic                                          databus_valid,
   output yolo_write_bus_pkg::wr_req_t                   databus_req,
   output logic                                          done
);

   localparam int AW = yolo_write_bus_pkg::IO_ADDR_W;

   yolo_write_cfg_pkg::layer_conf_t                   conf;
   logic                                              start;
   logic [N_STAGES-1:0][AW-1:0]                       base;
   logic [yolo_write_cfg_pkg::MEM_ADDR_W-1:0]         gen_addr;
   logic                                              gen_en;
   logic                                              busy;
   logic [N_STAGES-1:0]                               stage_req;
   yolo_write_bus_pkg::wr_req_t [N_STAGES-1:0]        stage_data;
   logic [N_STAGES-1:0]                               grants;
   logic                                              pending;
   logic                                              pause;

   conf_regs u_conf_regs (
      .clk   (clk),
      .rst   (rst),
      .clear (clear),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .run   (run),
      .conf  (conf),
      .start (start)
   );

   stage_base_calc #(
      .N_STAGES (N_STAGES)
   ) u_stage_base_calc (
      .clk      (clk),
      .rst      (rst),
      .ext_addr (conf.ext_addr),
      .offset   (conf.offset),
      .base     (base)
   );

   write_addr_gen u_write_addr_gen (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .pause (pause),
      .conf  (conf),
      .addr  (gen_addr),
      .en    (gen_en),
      .busy  (busy)
   );

   for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
      write_stage u_write_stage (
         .clk        (clk),
         .rst        (rst),
         .capture    (gen_en),
         .stage_base (base[i]),
         .int_addr   (gen_addr),
         .lane       (flow_in[i]),
         .grant      (grants[i]),
         .req        (stage_req[i]),
         .req_data   (stage_data[i])
      );
   end

   req_merge #(
      .N_STAGES (N_STAGES)
   ) u_req_merge (
      .reqs          (stage_req),
      .req_data      (stage_data),
      .databus_ready (databus_ready),
      .grants        (grants),
      .databus_valid (databus_valid),
      .databus_req   (databus_req)
   );

   // next address only once every stage has drained
   assign pause = |stage_req;

   // covers the gap between run and the generator going busy
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (run) begin
         pending <= 1'b1;
      end else if (start) begin
         pending <= 1'b0;
      end
   end

   assign done = ~pending & ~busy & ~(|stage_req);

endmodule

// ==== verification/yolo_write_assert.sv ====
`timescale 1ns/10ps

module yolo_write_assert (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        databus_valid,
   input  logic                        databus_ready,
   input  yolo_write_bus_pkg::wr_req_t databus_req,
   input  logic                        done
);

   // failed checks so far
   int fail_count = 0;

   // a request waiting for ready must not move or drop
   a_hold: assert property (@(posedge clk) disable iff (rst)
      databus_valid && !databus_ready |=> databus_valid && $stable(databus_req))
   else begin
      $error("databus request changed or dropped while ready was low");
      fail_count++;
   end

   a_done: assert property (@(posedge clk) disable iff (rst) databus_valid |-> !done)
   else begin
      $error("done was high while a databus request was valid");
      fail_count++;
   end

   a_reset: assert property (@(posedge clk) $fell(rst) |-> !databus_valid)
   else begin
      $error("databus valid was high right after reset");
      fail_count++;
   end

endmodule

// ==== verification/yolo_write_checker.sv ====
`timescale 1ns/10ps

module yolo_write_checker #(
   parameter int N_STAGES = 4
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          clear,
   input  logic                                          valid,
   input  logic [yolo_write_cfg_pkg::CPU_ADDR_W-1:0]     addr,
   input  logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]      wdata,
   input  logic                                          run,
   input  yolo_write_bus_pkg::bus_word_t [N_STAGES-1:0]  flow_in,
   input  logic                                          databus_ready,
   input  logic                                          databus_valid,
   input  yolo_write_bus_pkg::wr_req_t                   databus_req,
   input  logic                                          done,
   input  int                                            test_num,
   input  int                                            exp_count,
   output int                                            errors,
   output int                                            tests_done,
   output int                                            transfers
);

   localparam int MW = yolo_write_cfg_pkg::MEM_ADDR_W;
   localparam int AW = yolo_write_bus_pkg::IO_ADDR_W;

   // cpu view of the registers and the copy taken at run
   yolo_write_cfg_pkg::layer_conf_t work;
   yolo_write_cfg_pkg::layer_conf_t shadow;
   yolo_write_bus_pkg::wr_req_t     expq[$];
   logic                            active;
   logic                            run_q;
   int                              got;
   int                              test_errs;

   task automatic flag_error();
      errors++;
      test_errs++;
   endtask

   // loop order j, p, then stage 0 upwards
   task automatic predict_layer();
      yolo_write_bus_pkg::wr_req_t e;
      logic [MW-1:0]               ia;
      expq.delete();
      for (int j = 0; j < int'(shadow.iter); j++) begin
         for (int p = 0; p < int'(shadow.per); p++) begin
            ia = shadow.start + MW'(j) * shadow.shift + MW'(p) * shadow.incr;
            for (int i = 0; i < N_STAGES; i++) begin
               e.addr = shadow.ext_addr + AW'(i) * AW'(shadow.offset)
                  + (AW'(ia) << yolo_write_bus_pkg::WORD_SHIFT);
               e.wdata = flow_in[i];
               e.wstrb = '1;
               expq.push_back(e);
            end
         end
      end
   endtask

   task automatic finish_layer();
      if (expq.size() != 0) begin
         $display("test %0d: done rose with %0d transfers still missing", test_num, expq.size());
         flag_error();
      end
      if (got != exp_count) begin
         $display("test %0d: saw %0d transfers but the table expects %0d", test_num, got,
            exp_count);
         flag_error();
      end
      $display("test %0d finished: %0d transfers, %0d errors", test_num, got, test_errs);
      tests_done++;
      active = 1'b0;
   endtask

   always @(posedge clk) begin : monitor
      yolo_write_bus_pkg::wr_req_t want;
      if (rst) begin
         work = '0;
         shadow = '0;
         expq.delete();
         active = 1'b0;
         run_q = 1'b0;
         got = 0;
         test_errs = 0;
         errors = 0;
         tests_done = 0;
         transfers = 0;
      end else begin
         if (databus_valid && databus_ready) begin
            transfers++;
            got++;
            if (expq.size() == 0) begin
               $display("test %0d: unexpected transfer to %h at %0t", test_num,
                  databus_req.addr, $time);
               flag_error();
            end else begin
               want = expq.pop_front();
               if (databus_req !== want) begin
                  $display("[FAIL] %0t test %0d: got %h/%h/%h, expected %h/%h/%h", $time,
                     test_num, databus_req.addr, databus_req.wdata, databus_req.wstrb,
                     want.addr, want.wdata, want.wstrb);
                  flag_error();
               end
            end
         end
         // done must drop the cycle after run
         if (run_q) begin
            if (done) begin
               $display("[FAIL] %0t test %0d: done still high one cycle after run", $time,
                  test_num);
               flag_error();
            end
         end else if (active && done) begin
            finish_layer();
         end
         run_q = run;
         if (run) begin
            shadow = work;
            predict_layer();
            active = 1'b1;
            got = 0;
            test_errs = 0;
         end
         if (clear) begin
            work = '0;
         end else if (valid) begin
            case (addr)
               yolo_write_cfg_pkg::REG_EXT_ADDR: work.ext_addr = wdata;
               yolo_write_cfg_pkg::REG_OFFSET: work.offset = wdata[AW/2-1:0];
               yolo_write_cfg_pkg::REG_START: work.start = wdata[MW-1:0];
               yolo_write_cfg_pkg::REG_ITER: work.iter = wdata[MW-1:0];
               yolo_write_cfg_pkg::REG_PER: work.per = wdata[yolo_write_cfg_pkg::PERIOD_W-1:0];
               yolo_write_cfg_pkg::REG_SHIFT: work.shift = wdata[MW-1:0];
               yolo_write_cfg_pkg::REG_INCR: work.incr = wdata[MW-1:0];
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== verification/tb_yolo_write.sv ====
`timescale 1ns/10ps

module tb_yolo_write;

   localparam int N_STAGES = 4;
   localparam int N_TESTS = 6;

   // how a test sets up its registers
   localparam logic [1:0] MODE_WRITE = 2'd0;
   localparam logic [1:0] MODE_AHEAD = 2'd1;
   localparam logic [1:0] MODE_KEEP = 2'd2;
   localparam logic [1:0] MODE_CLEAR = 2'd3;

   // register words as the cpu writes them
   typedef struct packed {
      logic [31:0]                   ext_addr;
      logic [31:0]                   offset;
      logic [31:0]                   start;
      logic [31:0]                   iter;
      logic [31:0]                   per;
      logic [31:0]                   shift;
      logic [31:0]                   incr;
      yolo_write_bus_pkg::bus_word_t lane_seed;
      logic                          rnd_ready;
      logic [1:0]                    mode;
      logic [31:0]                   count;
   } test_t;

   localparam test_t TESTS [N_TESTS] = '{
      // ext_addr, offset, start, iter, per, shift, incr, lanes, random ready, mode, transfers
      '{'h1000_0000, 'h400, 5, 1, 1, 0, 0, 64'hA0A0_0000_0000_0001, 1'b0, MODE_WRITE, 4},
      '{'h2000_0000, 'h100, 'h3F0, 3, 4, 'h40, 3, 64'hB0B0_0000_0000_0002, 1'b0, MODE_WRITE, 48},
      '{'h2000_0000, 'h100, 'h3F0, 3, 4, 'h40, 3, 64'hB0B0_0000_0000_0002, 1'b1, MODE_WRITE, 48},
      '{'h3000_0000, 'h80, 10, 2, 3, 16, 1, 64'hC0C0_0000_0000_0003, 1'b0, MODE_AHEAD, 24},
      '{'h4000_0000, 'h200, 100, 2, 2, 7, 2, 64'hD0D0_0000_0000_0004, 1'b1, MODE_KEEP, 16},
      '{0, 0, 0, 0, 0, 0, 0, 64'hE0E0_0000_0000_0005, 1'b0, MODE_CLEAR, 0}
   };

   logic                                          clk = 1'b0;
   logic                                          rst;
   logic                                          clear;
   logic                                          valid;
   logic [yolo_write_cfg_pkg::CPU_ADDR_W-1:0]     addr;
   logic [yolo_write_bus_pkg::IO_ADDR_W-1:0]      wdata;
   logic                                          run;
   yolo_write_bus_pkg::bus_word_t [N_STAGES-1:0]  flow_in;
   logic                                          databus_ready;
   logic                                          databus_valid;
   yolo_write_bus_pkg::wr_req_t                   databus_req;
   logic                                          done;
   int                                            test_num;
   int                                            exp_count;
   int                                            errors;
   int                                            tests_done;
   int                                            transfers;
   logic                                          rnd_ready;
   integer                                        seed = 41;

   yolo_write_top #(.N_STAGES(N_STAGES)) u_yolo_write_top (.*);

   yolo_write_checker #(.N_STAGES(N_STAGES)) u_checker (.*);

   bind yolo_write_top yolo_write_assert u_assert (
      .clk           (clk),
      .rst           (rst),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_req   (databus_req),
      .done          (done)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   // ready is high unless the test asks for back-pressure
   initial begin : ready_drive
      int r;
      databus_ready = 1'b1;
      forever begin
         @(negedge clk);
         r = $random(seed);
         databus_ready = rnd_ready ? r[0] : 1'b1;
      end
   end

   task automatic write_reg(input logic [yolo_write_cfg_pkg::CPU_ADDR_W-1:0] a,
                            input logic [31:0] d);
      valid = 1'b1;
      addr = a;
      wdata = d;
      @(negedge clk);
      valid = 1'b0;
   endtask

   task automatic write_conf(input test_t c);
      write_reg(yolo_write_cfg_pkg::REG_EXT_ADDR, c.ext_addr);
      write_reg(yolo_write_cfg_pkg::REG_OFFSET, c.offset);
      write_reg(yolo_write_cfg_pkg::REG_START, c.start);
      write_reg(yolo_write_cfg_pkg::REG_ITER, c.iter);
      write_reg(yolo_write_cfg_pkg::REG_PER, c.per);
      write_reg(yolo_write_cfg_pkg::REG_SHIFT, c.shift);
      write_reg(yolo_write_cfg_pkg::REG_INCR, c.incr);
   endtask

   initial begin : watchdog
      int limit;
      int cycles;
      limit = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         limit += 10 + 4 * int'(TESTS[t].count) * N_STAGES;
      end
      cycles = 0;
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
   end

   initial begin : stimulus
      test_t cur;
      rst = 1'b1;
      clear = 1'b0;
      valid = 1'b0;
      addr = '0;
      wdata = '0;
      run = 1'b0;
      flow_in = '0;
      rnd_ready = 1'b0;
      test_num = 0;
      exp_count = 0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      for (int t = 0; t < N_TESTS; t++) begin
         cur = TESTS[t];
         test_num = t;
         exp_count = int'(cur.count);
         rnd_ready = cur.rnd_ready;
         for (int i = 0; i < N_STAGES; i++) begin
            flow_in[i] = cur.lane_seed ^ (64'(i) * 64'h0101_0101_0101_0101);
         end
         if (cur.mode == MODE_CLEAR) begin
            clear = 1'b1;
            @(negedge clk);
            clear = 1'b0;
         end else if (cur.mode != MODE_KEEP) begin
            write_conf(cur);
         end
         run = 1'b1;
         @(negedge clk);
         run = 1'b0;
         // next layer is set up while this one runs
         if (cur.mode == MODE_AHEAD) begin
            write_conf(TESTS[t + 1]);
         end
         while (!done) @(negedge clk);
         @(negedge clk);
      end
      $display("summary: %0d of %0d tests, %0d transfers, %0d errors, %0d assertion failures",
         tests_done, N_TESTS, transfers, errors, u_yolo_write_top.u_assert.fail_count);
      if (errors == 0 && tests_done == N_TESTS && u_yolo_write_top.u_assert.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== yolo_write_top.f ====
hdl/yolo_write_bus_pkg.sv
hdl/yolo_write_cfg_pkg.sv
hdl/conf_regs.sv
hdl/stage_base_calc.sv
hdl/write_addr_gen.sv
hdl/write_stage.sv
hdl/req_merge.sv
hdl/yolo_write_top.sv
verification/yolo_write_assert.sv
verification/yolo_write_checker.sv
verification/tb_yolo_write.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f yolo_write_top.f --top-module tb_yolo_write -Mdir obj_dir -o sim_yolo_write
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_yolo_write +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
   exit 0
fi
exit 1
